//--- vlog.f
+incdir+source
source/bus_pkg.sv
source/bus_req_arbiter.sv
source/bus_lane_align.sv
source/bus_clint.sv
source/bus_top.sv
sim/tb_clk_gen.sv
sim/axi_mem_model.sv
sim/tb_bus_top.sv

//--- Bender.yml
package:
  name: bus_top

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/bus_pkg.sv
      - source/bus_req_arbiter.sv
      - source/bus_lane_align.sv
      - source/bus_clint.sv
      - source/bus_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clk_gen.sv
      - sim/axi_mem_model.sv
      - sim/tb_bus_top.sv

//--- sim/tb_bus_top.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module tb_bus_top;

  logic             clk;
  logic             rst;
  logic [31:0]      ifu_addr;
  logic [31:0]      lsu_raddr;
  logic [31:0]      lsu_waddr;
  logic [31:0]      lsu_wdata;
  logic             ifu_valid;
  logic             lsu_rvalid;
  logic             lsu_wvalid;
  logic [7:0]       lsu_rstrb;
  logic [7:0]       lsu_wstrb;
  logic [31:0]      ifu_rdata;
  logic [31:0]      lsu_rdata;
  logic             ifu_rvalid;
  logic             lsu_rdone;
  logic             lsu_wready;
  bus_pkg::axi_ar_t ar;
  bus_pkg::axi_aw_t aw;
  bus_pkg::axi_w_t  w;
  bus_pkg::axi_r_t  r;
  logic             arvalid;
  logic             arready;
  logic             rvalid;
  logic             rready;
  logic             awvalid;
  logic             awready;
  logic             wvalid;
  logic             wready;
  logic             bvalid;
  logic             bready;

  // reference image of memory kept in step with completed stores
  logic [7:0]  shadow [0:255];
  logic [31:0] exp_ifu;
  logic [31:0] exp_lsu;
  logic [31:0] exp_wlane;
  logic [31:0] last_mt;
  logic [7:0]  exp_wstrb;
  logic [2:0]  exp_lsu_size;
  logic [2:0]  exp_wr_size;
  logic        lsu_mt;
  logic        lsu_axi_wait;
  logic        ar_prev;
  logic        rd_inflight;
  int          mt_age;
  int          cycles;

  tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

  bus_top uut (
    .clk(clk), .rst(rst),
    .ifu_addr_i(ifu_addr), .ifu_valid_i(ifu_valid),
    .ifu_rdata_o(ifu_rdata), .ifu_rvalid_o(ifu_rvalid),
    .lsu_raddr_i(lsu_raddr), .lsu_rvalid_i(lsu_rvalid), .lsu_rstrb_i(lsu_rstrb),
    .lsu_rdata_o(lsu_rdata), .lsu_rdone_o(lsu_rdone),
    .lsu_waddr_i(lsu_waddr), .lsu_wdata_i(lsu_wdata), .lsu_wstrb_i(lsu_wstrb),
    .lsu_wvalid_i(lsu_wvalid), .lsu_wready_o(lsu_wready),
    .axi_ar_o(ar), .axi_arvalid_o(arvalid), .axi_arready_i(arready),
    .axi_r_i(r), .axi_rvalid_i(rvalid), .axi_rready_o(rready),
    .axi_aw_o(aw), .axi_awvalid_o(awvalid), .axi_awready_i(awready),
    .axi_w_o(w), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
    .axi_bvalid_i(bvalid), .axi_bready_o(bready)
  );

  axi_mem_model u_mem (
    .clk_i(clk), .rst_i(rst),
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
    .r_o(r), .rvalid_o(rvalid),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready), .bvalid_o(bvalid)
  );

  // access width in bytes from the unshifted strobe
  function automatic int strb_bytes(input logic [7:0] strb);
    return (strb == 8'h01) ? 1 : (strb == 8'h03) ? 2 : 4;
  endfunction

  // axsize is log2 of the access width
  function automatic logic [2:0] size_code(input logic [7:0] strb);
    return (strb_bytes(strb) == 1) ? 3'd0
         : (strb_bytes(strb) == 2) ? 3'd1 : 3'd2;
  endfunction

  // little endian and zero extended
  function automatic logic [31:0] load_value(input logic [31:0] addr, input logic [7:0] strb);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < strb_bytes(strb); b++)
      v[8*b +: 8] = shadow[addr[7:0] + b];
    return v;
  endfunction

  always_comb
  begin
    exp_ifu      = load_value(ifu_addr, 8'h0F);
    exp_lsu      = load_value(lsu_raddr, lsu_rstrb);
    exp_lsu_size = size_code(lsu_rstrb);
    exp_wr_size  = size_code(lsu_wstrb);
    lsu_mt       = (lsu_raddr == `BUS_MTIME_LO) || (lsu_raddr == `BUS_MTIME_HI);
    lsu_axi_wait = lsu_rvalid && !lsu_mt;
    // strobe moved by the offset into its half and data repeated in both
    exp_wstrb    = ({4'b0, lsu_wstrb[3:0]} << lsu_waddr[1:0]) << (lsu_waddr[2] ? 4 : 0);
    exp_wlane    = lsu_wdata << (8 * lsu_waddr[1:0]);
  end

  // cycle bookkeeping for the checks
  always @(posedge clk)
  begin
    ar_prev <= rst ? 1'b0 : arvalid;
    if (rst || (rvalid && rready))
      rd_inflight <= 1'b0;
    else if (arvalid && arready)
      rd_inflight <= 1'b1;
    mt_age <= lsu_rvalid ? mt_age + 1 : 0;
    if (rst)
      last_mt <= '0;
    else if (lsu_rdone && lsu_raddr == `BUS_MTIME_LO)
      last_mt <= lsu_rdata;
  end

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("** Error: %s expected %h got %h", name, exp, got);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic plain_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // returned data per requester
  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid |-> ifu_rdata == exp_ifu)
    else value_error("ifu_rdata_o", $sampled(exp_ifu), $sampled(ifu_rdata));
  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
    (lsu_rdone && !lsu_mt) |-> lsu_rdata == exp_lsu)
    else value_error("lsu_rdata_o", $sampled(exp_lsu), $sampled(lsu_rdata));
  a_ifu_own: assert property (@(posedge clk) disable iff (rst) ifu_rvalid |-> ifu_valid)
    else plain_error("ifu got a read response with no fetch pending");
  a_lsu_own: assert property (@(posedge clk) disable iff (rst) lsu_rdone |-> lsu_rvalid)
    else plain_error("lsu got a read response with no load pending");

  // ar fields
  a_ar_lsu: assert property (@(posedge clk) disable iff (rst)
    (arvalid && !ar_prev && lsu_axi_wait) |-> ar.id == `BUS_ID_LSU)
    else value_error("axi_ar_o.id", `BUS_ID_LSU, $sampled(ar.id));
  a_ar_ifu: assert property (@(posedge clk) disable iff (rst)
    (arvalid && !ar_prev && !lsu_axi_wait) |-> (ar.id == `BUS_ID_IFU && ar.size == 3'd2))
    else value_error("axi_ar_o.id/size", {`BUS_ID_IFU, 3'd2}, $sampled({ar.id, ar.size}));
  a_ar_size: assert property (@(posedge clk) disable iff (rst)
    (arvalid && ar.id == `BUS_ID_LSU) |-> ar.size == exp_lsu_size)
    else value_error("axi_ar_o.size", $sampled(exp_lsu_size), $sampled(ar.size));
  a_ar_beat: assert property (@(posedge clk) disable iff (rst) arvalid |-> ar.len == 8'd0)
    else value_error("axi_ar_o.len", 8'd0, $sampled(ar.len));
  a_one_read: assert property (@(posedge clk) disable iff (rst) rd_inflight |-> !arvalid)
    else plain_error("a second read address was issued while a read was in flight");

  // responses are always accepted
  a_resp_ready: assert property (@(posedge clk) disable iff (rst) rready && bready)
    else value_error("axi_rready_o/axi_bready_o", 2'b11, $sampled({rready, bready}));

  // store lanes
  a_aw_size: assert property (@(posedge clk) disable iff (rst)
    awvalid |-> (aw.size == exp_wr_size && aw.len == 8'd0))
    else value_error("axi_aw_o.size/len", $sampled({exp_wr_size, 8'd0}),
                     $sampled({aw.size, aw.len}));
  a_wstrb: assert property (@(posedge clk) disable iff (rst) wvalid |-> w.strb == exp_wstrb)
    else value_error("axi_w_o.strb", $sampled(exp_wstrb), $sampled(w.strb));
  a_wdata: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> w.data == {exp_wlane, exp_wlane})
    else value_error("axi_w_o.data", $sampled({exp_wlane, exp_wlane}), $sampled(w.data));
  a_wlast: assert property (@(posedge clk) disable iff (rst) wvalid |-> w.last)
    else plain_error("a write data beat was sent without wlast");

  // mtime loads stay local
  a_mt_noar: assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid && lsu_mt && !ifu_valid) |-> !arvalid)
    else plain_error("an mtime load went out on the read address channel");
  a_mt_late: assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid && lsu_mt && mt_age == 1) |-> lsu_rdone)
    else plain_error("mtime load was not answered one cycle after the request");
  a_mt_early: assert property (@(posedge clk) disable iff (rst)
    (lsu_rdone && lsu_mt) |-> mt_age == 1)
    else plain_error("mtime load was answered at the wrong cycle");
  a_mt_inc: assert property (@(posedge clk) disable iff (rst)
    (lsu_rdone && lsu_raddr == `BUS_MTIME_LO) |-> lsu_rdata > last_mt)
    else value_error("lsu_rdata_o (mtime)", $sampled(last_mt) + 1, $sampled(lsu_rdata));

  // held until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (arvalid && !arready) |=> (arvalid && $stable(ar)))
    else plain_error("arvalid dropped or the ar payload changed before arready");
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    (awvalid && !awready) |=> (awvalid && $stable(aw)))
    else plain_error("awvalid dropped or the aw payload changed before awready");
  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    (wvalid && !wready) |=> (wvalid && $stable(w)))
    else plain_error("wvalid dropped or the w payload changed before wready");

  // run limit covers about 60 transactions of at most 20 cycles
  always @(posedge clk)
  begin
    cycles++;
    if (cycles == 4000)
      plain_error("timeout, the run did not finish within 4000 cycles");
  end

  // every task starts and ends 1 ns after an edge
  task automatic fetch_word(input logic [31:0] addr);
    ifu_addr  = addr;
    ifu_valid = 1'b1;
    do @(posedge clk); while (!ifu_rvalid);
    #1 ifu_valid = 1'b0;
  endtask

  task automatic load(input logic [31:0] addr, input logic [7:0] strb);
    lsu_raddr  = addr;
    lsu_rstrb  = strb;
    lsu_rvalid = 1'b1;
    do @(posedge clk); while (!lsu_rdone);
    #1 lsu_rvalid = 1'b0;
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [7:0] strb);
    lsu_waddr  = addr;
    lsu_wdata  = data;
    lsu_wstrb  = strb;
    lsu_wvalid = 1'b1;
    do @(posedge clk); while (!lsu_wready);
    for (int b = 0; b < strb_bytes(strb); b++)
      shadow[addr[7:0] + b] = data[8*b +: 8];
    #1 lsu_wvalid = 1'b0;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    ifu_addr = '0;
    ifu_valid = 1'b0;
    lsu_raddr = '0;
    lsu_rvalid = 1'b0;
    lsu_rstrb = 8'h0F;
    lsu_waddr = '0;
    lsu_wdata = '0;
    lsu_wstrb = 8'h0F;
    lsu_wvalid = 1'b0;
    cycles = 0;
    mt_age = 0;
    for (int i = 0; i < 256; i++)
      shadow[i] = i[7:0] + 8'h5A;
    wait (!rst);
    idle();
    for (int i = 0; i < 8; i++)
    begin
      fetch_word(32'h8000_0000 + 4 * i);
      idle();
    end
    for (int o = 0; o < 8; o++)
    begin
      load(32'h8000_0020 + o, 8'h01);
      idle();
    end
    for (int o = 0; o < 7; o++)
      if (o != 3)
      begin
        load(32'h8000_0028 + o, 8'h03);
        idle();
      end
    // stores at every offset and a read back
    for (int o = 0; o < 8; o++)
    begin
      store(32'h8000_0040 + o, 32'hA1B2_C300 + o, 8'h01);
      idle();
    end
    for (int o = 0; o < 8; o += 2)
    begin
      store(32'h8000_0050 + o, 32'h0000_7E10 + o, 8'h03);
      idle();
    end
    store(32'h8000_0060, 32'hDEAD_BEEF, 8'h0F);
    idle();
    store(32'h8000_0064, 32'h1234_5678, 8'h0F);
    idle();
    for (int a = 'h40; a < 'h68; a += 4)
    begin
      load(32'h8000_0000 + a, 8'h0F);
      idle();
    end
    // both requesters in the same cycle
    for (int i = 0; i < 3; i++)
    begin
      fork
        fetch_word(32'h8000_0080 + 8 * i);
        load(32'h8000_0090 + 4 * i, 8'h0F);
      join
      idle();
    end
    for (int i = 0; i < 4; i++)
    begin
      load(`BUS_MTIME_LO, 8'h0F);
      idle();
    end
    load(`BUS_MTIME_HI, 8'h0F);
    idle();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_mem_model (
  input  logic             clk_i,
  input  logic             rst_i,
  input  bus_pkg::axi_ar_t ar_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  output bus_pkg::axi_r_t  r_o,
  output logic             rvalid_o,
  input  bus_pkg::axi_aw_t aw_i,
  input  logic             awvalid_i,
  output logic             awready_o,
  input  bus_pkg::axi_w_t  w_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  output logic             bvalid_o
);

  logic [7:0]       mem [0:255];
  logic [31:0]      rng;
  bus_pkg::axi_ar_t ar_q;
  bus_pkg::axi_aw_t aw_q;
  bus_pkg::axi_w_t  w_q;
  logic             aw_got;
  logic             w_got;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 0 to 5 cycles from the upper state bits
  task automatic pick_delay(output int d);
    rng = lcg_next(rng);
    d = rng[23:16] % 6;
  endtask

  initial
  begin
    rng = 32'h9387_57ef;
    // byte i holds i + 0x5a
    for (int i = 0; i < 256; i++)
      mem[i] = i[7:0] + 8'h5A;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    r_o       = '0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    aw_got    = 1'b0;
    w_got     = 1'b0;
  end

  // read channel, one at a time
  always
  begin
    int d;
    @(posedge clk_i);
    if (!rst_i && arvalid_i)
    begin
      pick_delay(d);
      repeat (d) @(posedge clk_i);
      #1 arready_o = 1'b1;
      @(posedge clk_i);
      ar_q = ar_i;
      #1 arready_o = 1'b0;
      pick_delay(d);
      repeat (d) @(posedge clk_i);
      #1;
      // whole doubleword, id echoed
      for (int i = 0; i < 8; i++)
        r_o.data[8*i +: 8] = mem[{ar_q.addr[7:3], 3'b000} + i];
      r_o.id   = ar_q.id;
      r_o.resp = 2'b00;
      r_o.last = 1'b1;
      rvalid_o = 1'b1;
      @(posedge clk_i);
      #1 rvalid_o = 1'b0;
    end
  end

  // aw accepted once per write
  always
  begin
    int d;
    @(posedge clk_i);
    if (!rst_i && awvalid_i && !aw_got)
    begin
      pick_delay(d);
      repeat (d) @(posedge clk_i);
      #1 awready_o = 1'b1;
      @(posedge clk_i);
      aw_q = aw_i;
      aw_got = 1'b1;
      #1 awready_o = 1'b0;
    end
  end

  always
  begin
    int d;
    @(posedge clk_i);
    if (!rst_i && wvalid_i && !w_got)
    begin
      pick_delay(d);
      repeat (d) @(posedge clk_i);
      #1 wready_o = 1'b1;
      @(posedge clk_i);
      w_q = w_i;
      w_got = 1'b1;
      #1 wready_o = 1'b0;
    end
  end

  // b after both halves, memory updated by strobe
  always
  begin
    int d;
    @(posedge clk_i);
    if (aw_got && w_got)
    begin
      pick_delay(d);
      repeat (d) @(posedge clk_i);
      for (int i = 0; i < 8; i++)
        if (w_q.strb[i])
          mem[{aw_q.addr[7:3], 3'b000} + i] = w_q.data[8*i +: 8];
      #1 bvalid_o = 1'b1;
      @(posedge clk_i);
      #1;
      bvalid_o = 1'b0;
      aw_got   = 1'b0;
      w_got    = 1'b0;
    end
  end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 100 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held for 4 rising edges
  initial
  begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- source/bus_top.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_top (
  input  logic                       clk,
  input  logic                       rst,
  // instruction fetch
  input  logic [`BUS_ADDR_W-1:0]     ifu_addr_i,
  input  logic                       ifu_valid_i,
  output logic [`BUS_DATA_W-1:0]     ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  // load
  input  logic [`BUS_ADDR_W-1:0]     lsu_raddr_i,
  input  logic                       lsu_rvalid_i,
  input  logic [`BUS_AXI_STRB_W-1:0] lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]     lsu_rdata_o,
  output logic                       lsu_rdone_o,
  // store
  input  logic [`BUS_ADDR_W-1:0]     lsu_waddr_i,
  input  logic [`BUS_DATA_W-1:0]     lsu_wdata_i,
  input  logic [`BUS_AXI_STRB_W-1:0] lsu_wstrb_i,
  input  logic                       lsu_wvalid_i,
  output logic                       lsu_wready_o,
  // axi4 master
  output bus_pkg::axi_ar_t           axi_ar_o,
  output logic                       axi_arvalid_o,
  input  logic                       axi_arready_i,
  input  bus_pkg::axi_r_t            axi_r_i,
  input  logic                       axi_rvalid_i,
  output logic                       axi_rready_o,
  output bus_pkg::axi_aw_t           axi_aw_o,
  output logic                       axi_awvalid_o,
  input  logic                       axi_awready_i,
  output bus_pkg::axi_w_t            axi_w_o,
  output logic                       axi_wvalid_o,
  input  logic                       axi_wready_i,
  input  logic                       axi_bvalid_i,
  output logic                       axi_bready_o
);

  // arbiter to lane stage
  bus_pkg::bus_rd_req_t   rd_req;
  logic                   rd_valid;
  bus_pkg::req_owner_e    rd_owner;
  logic                   rd_accept;
  bus_pkg::bus_rd_rsp_t   rd_rsp;
  logic                   rd_rsp_valid;
  bus_pkg::bus_wr_req_t   wr_req;
  logic                   wr_valid;
  logic                   wr_done;
  // arbiter to clint
  logic                   clint_rd;
  logic                   clint_hi;
  logic [`BUS_DATA_W-1:0] clint_rdata;
  logic                   clint_rvalid;

  bus_req_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_addr_i     (ifu_addr_i),
    .ifu_valid_i    (ifu_valid_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_raddr_i    (lsu_raddr_i),
    .lsu_rvalid_i   (lsu_rvalid_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rdone_o    (lsu_rdone_o),
    .lsu_waddr_i    (lsu_waddr_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_wready_o   (lsu_wready_o),
    .rd_req_o       (rd_req),
    .rd_valid_o     (rd_valid),
    .rd_owner_o     (rd_owner),
    .rd_accept_i    (rd_accept),
    .rd_rsp_i       (rd_rsp),
    .rd_rsp_valid_i (rd_rsp_valid),
    .wr_req_o       (wr_req),
    .wr_valid_o     (wr_valid),
    .wr_done_i      (wr_done),
    .clint_rd_o     (clint_rd),
    .clint_hi_o     (clint_hi),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid)
  );

  bus_lane_align u_lane (
    .clk            (clk),
    .rst            (rst),
    .rd_req_i       (rd_req),
    .rd_valid_i     (rd_valid),
    .rd_owner_i     (rd_owner),
    .rd_accept_o    (rd_accept),
    .rd_rsp_o       (rd_rsp),
    .rd_rsp_valid_o (rd_rsp_valid),
    .wr_req_i       (wr_req),
    .wr_valid_i     (wr_valid),
    .wr_done_o      (wr_done),
    .axi_ar_o       (axi_ar_o),
    .axi_arvalid_o  (axi_arvalid_o),
    .axi_arready_i  (axi_arready_i),
    .axi_r_i        (axi_r_i),
    .axi_rvalid_i   (axi_rvalid_i),
    .axi_rready_o   (axi_rready_o),
    .axi_aw_o       (axi_aw_o),
    .axi_awvalid_o  (axi_awvalid_o),
    .axi_awready_i  (axi_awready_i),
    .axi_w_o        (axi_w_o),
    .axi_wvalid_o   (axi_wvalid_o),
    .axi_wready_i   (axi_wready_i),
    .axi_bvalid_i   (axi_bvalid_i),
    .axi_bready_o   (axi_bready_o)
  );

  // mtime answers lsu loads locally
  bus_clint u_clint (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .hi_i     (clint_hi),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

endmodule

//--- source/bus_clint.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_clint (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_i,
  input  logic                   hi_i,
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o
);

  logic [63:0]            mtime_q;
  logic [`BUS_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;

  // free running, one tick per clock
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  // sample the selected word on the strobe edge
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= hi_i ? mtime_q[63:32] : mtime_q[31:0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= rd_i;
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- source/bus_lane_align.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_lane_align (
  input  logic                 clk,
  input  logic                 rst,
  // from arbiter
  input  bus_pkg::bus_rd_req_t rd_req_i,
  input  logic                 rd_valid_i,
  input  bus_pkg::req_owner_e  rd_owner_i,
  output logic                 rd_accept_o,
  output bus_pkg::bus_rd_rsp_t rd_rsp_o,
  output logic                 rd_rsp_valid_o,
  input  bus_pkg::bus_wr_req_t wr_req_i,
  input  logic                 wr_valid_i,
  output logic                 wr_done_o,
  // axi read
  output bus_pkg::axi_ar_t     axi_ar_o,
  output logic                 axi_arvalid_o,
  input  logic                 axi_arready_i,
  input  bus_pkg::axi_r_t      axi_r_i,
  input  logic                 axi_rvalid_i,
  output logic                 axi_rready_o,
  // axi write
  output bus_pkg::axi_aw_t     axi_aw_o,
  output logic                 axi_awvalid_o,
  input  logic                 axi_awready_i,
  output bus_pkg::axi_w_t      axi_w_o,
  output logic                 axi_wvalid_o,
  input  logic                 axi_wready_i,
  input  logic                 axi_bvalid_i,
  output logic                 axi_bready_o
);

  // axsize from the byte strobe
  function automatic logic [2:0] size_of(input logic [`BUS_AXI_STRB_W-1:0] strb);
    logic [2:0] size;
    case (strb)
      8'h01:   size = 3'd0;
      8'h03:   size = 3'd1;
      default: size = 3'd2;
    endcase
    return size;
  endfunction

  logic [2:0]             rd_lo_q;
  logic [2:0]             rd_size_q;
  logic [`BUS_DATA_W-1:0] r_half;
  logic [`BUS_DATA_W-1:0] r_shift;
  logic [`BUS_DATA_W-1:0] r_mask;
  logic                   aw_sent_q;
  logic                   w_sent_q;
  logic [1:0]             wr_off;
  logic [`BUS_DATA_W-1:0] wr_lane;
  logic [3:0]             wr_nib;

  // single beat incr read
  assign axi_ar_o.addr  = rd_req_i.addr;
  assign axi_ar_o.size  = size_of(rd_req_i.strb);
  assign axi_ar_o.len   = 8'd0;
  assign axi_ar_o.burst = 2'b01;
  assign axi_ar_o.id    = (rd_owner_i == bus_pkg::OWNER_LSU) ? `BUS_ID_LSU : `BUS_ID_IFU;
  assign axi_arvalid_o  = rd_valid_i;
  assign rd_accept_o    = rd_valid_i & axi_arready_i;

  // offset and size kept for the r beat
  always_ff @(posedge clk)
  begin
    if (rd_accept_o)
    begin
      rd_lo_q   <= rd_req_i.addr[2:0];
      rd_size_q <= axi_ar_o.size;
    end
  end

  // pick the half, then drop the low bytes
  assign r_half  = rd_lo_q[2] ? axi_r_i.data[`BUS_AXI_DATA_W-1:`BUS_DATA_W]
                              : axi_r_i.data[`BUS_DATA_W-1:0];
  assign r_shift = r_half >> {rd_lo_q[1:0], 3'b000};

  always_comb
  begin
    case (rd_size_q)
      3'd0:    r_mask = 32'h0000_00FF;
      3'd1:    r_mask = 32'h0000_FFFF;
      default: r_mask = 32'hFFFF_FFFF;
    endcase
  end

  // zero extended to the access size
  assign rd_rsp_o.data  = r_shift & r_mask;
  assign rd_rsp_o.owner = (axi_r_i.id == `BUS_ID_LSU) ? bus_pkg::OWNER_LSU
                                                      : bus_pkg::OWNER_IFU;
  assign rd_rsp_valid_o = axi_rvalid_i;
  assign axi_rready_o   = 1'b1;

  // store lanes
  assign wr_off  = wr_req_i.addr[1:0];
  assign wr_lane = wr_req_i.data << {wr_off, 3'b000};
  assign wr_nib  = wr_req_i.strb[3:0] << wr_off;

  assign axi_aw_o.addr  = wr_req_i.addr;
  assign axi_aw_o.size  = size_of(wr_req_i.strb);
  assign axi_aw_o.len   = 8'd0;
  assign axi_aw_o.burst = 2'b01;
  assign axi_aw_o.id    = `BUS_ID_LSU;

  // data in both halves, strobe picks the half
  assign axi_w_o.data = {wr_lane, wr_lane};
  assign axi_w_o.strb = wr_req_i.addr[2] ? {wr_nib, 4'b0000} : {4'b0000, wr_nib};
  assign axi_w_o.last = 1'b1;

  assign axi_awvalid_o = wr_valid_i & ~aw_sent_q;
  assign axi_wvalid_o  = wr_valid_i & ~w_sent_q;

  // aw and w retire on their own handshakes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end
    else if (axi_bvalid_i)
    begin
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end
    else
    begin
      if (axi_awvalid_o & axi_awready_i)
        aw_sent_q <= 1'b1;
      if (axi_wvalid_o & axi_wready_i)
        w_sent_q <= 1'b1;
    end
  end

  assign wr_done_o    = axi_bvalid_i;
  assign axi_bready_o = 1'b1;

endmodule

//--- source/bus_req_arbiter.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_req_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  // instruction fetch
  input  logic [`BUS_ADDR_W-1:0]      ifu_addr_i,
  input  logic                        ifu_valid_i,
  output logic [`BUS_DATA_W-1:0]      ifu_rdata_o,
  output logic                        ifu_rvalid_o,
  // load
  input  logic [`BUS_ADDR_W-1:0]      lsu_raddr_i,
  input  logic                        lsu_rvalid_i,
  input  logic [`BUS_AXI_STRB_W-1:0]  lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]      lsu_rdata_o,
  output logic                        lsu_rdone_o,
  // store
  input  logic [`BUS_ADDR_W-1:0]      lsu_waddr_i,
  input  logic [`BUS_DATA_W-1:0]      lsu_wdata_i,
  input  logic [`BUS_AXI_STRB_W-1:0]  lsu_wstrb_i,
  input  logic                        lsu_wvalid_i,
  output logic                        lsu_wready_o,
  // lane stage
  output bus_pkg::bus_rd_req_t        rd_req_o,
  output logic                        rd_valid_o,
  output bus_pkg::req_owner_e         rd_owner_o,
  input  logic                        rd_accept_i,
  input  bus_pkg::bus_rd_rsp_t        rd_rsp_i,
  input  logic                        rd_rsp_valid_i,
  output bus_pkg::bus_wr_req_t        wr_req_o,
  output logic                        wr_valid_o,
  input  logic                        wr_done_i,
  // clint
  output logic                        clint_rd_o,
  output logic                        clint_hi_o,
  input  logic [`BUS_DATA_W-1:0]      clint_rdata_i,
  input  logic                        clint_rvalid_i
);

  logic                lsu_mtime;
  logic                lsu_axi_rd;
  logic                ar_pend_q;
  logic                rd_busy_q;
  logic                clint_pend_q;
  bus_pkg::req_owner_e owner_q;
  bus_pkg::req_owner_e grant_owner;

  // mtime loads never go out on axi
  assign lsu_mtime  = (lsu_raddr_i == `BUS_MTIME_LO) || (lsu_raddr_i == `BUS_MTIME_HI);
  assign lsu_axi_rd = lsu_rvalid_i & ~lsu_mtime;

  // fixed priority, lsu wins
  assign grant_owner = lsu_axi_rd ? bus_pkg::OWNER_LSU : bus_pkg::OWNER_IFU;

  // owner frozen once arvalid is up
  assign rd_owner_o = ar_pend_q ? owner_q : grant_owner;
  assign rd_valid_o = ar_pend_q | (~rd_busy_q & (ifu_valid_i | lsu_axi_rd));

  always_comb
  begin
    if (rd_owner_o == bus_pkg::OWNER_LSU)
    begin
      rd_req_o.addr = lsu_raddr_i;
      rd_req_o.strb = lsu_rstrb_i;
    end
    else
    begin
      // fetch is always a full word
      rd_req_o.addr = ifu_addr_i;
      rd_req_o.strb = 8'h0F;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ar_pend_q    <= 1'b0;
      rd_busy_q    <= 1'b0;
      owner_q      <= bus_pkg::OWNER_IFU;
      clint_pend_q <= 1'b0;
    end
    else
    begin
      // ar waiting for arready
      if (rd_accept_i)
        ar_pend_q <= 1'b0;
      else if (rd_valid_o)
        ar_pend_q <= 1'b1;
      // in flight from ar handshake to r beat
      if (rd_accept_i)
        rd_busy_q <= 1'b1;
      else if (rd_rsp_valid_i)
        rd_busy_q <= 1'b0;
      if (rd_valid_o & ~ar_pend_q)
        owner_q <= grant_owner;
      // one strobe per held mtime load
      if (clint_rd_o)
        clint_pend_q <= 1'b1;
      else if (clint_rvalid_i)
        clint_pend_q <= 1'b0;
    end
  end

  assign clint_rd_o = lsu_rvalid_i & lsu_mtime & ~clint_pend_q;
  assign clint_hi_o = (lsu_raddr_i == `BUS_MTIME_HI);

  // route by owner recovered from rid
  assign ifu_rdata_o  = rd_rsp_i.data;
  assign ifu_rvalid_o = ifu_valid_i & rd_rsp_valid_i
                      & (rd_rsp_i.owner == bus_pkg::OWNER_IFU);
  assign lsu_rdata_o  = clint_rvalid_i ? clint_rdata_i : rd_rsp_i.data;
  assign lsu_rdone_o  = lsu_rvalid_i
                      & (clint_rvalid_i
                         | (rd_rsp_valid_i & (rd_rsp_i.owner == bus_pkg::OWNER_LSU)));

  // store path, lane stage keeps one in flight
  assign wr_req_o.addr = lsu_waddr_i;
  assign wr_req_o.data = lsu_wdata_i;
  assign wr_req_o.strb = lsu_wstrb_i;
  assign wr_valid_o    = lsu_wvalid_i;
  assign lsu_wready_o  = lsu_wvalid_i & wr_done_i;

endmodule

//--- source/bus_pkg.sv
`include "bus_config.svh"

package bus_pkg;

  // requester that owns a read
  typedef enum logic {
    OWNER_IFU = 1'b0,
    OWNER_LSU = 1'b1
  } req_owner_e;

  // read from arbiter to lane stage
  typedef struct packed {
    logic [`BUS_ADDR_W-1:0]     addr;
    logic [`BUS_AXI_STRB_W-1:0] strb;
  } bus_rd_req_t;

  // store from arbiter to lane stage
  typedef struct packed {
    logic [`BUS_ADDR_W-1:0]     addr;
    logic [`BUS_DATA_W-1:0]     data;
    logic [`BUS_AXI_STRB_W-1:0] strb;
  } bus_wr_req_t;

  // ar channel payload
  typedef struct packed {
    logic [`BUS_ADDR_W-1:0]   addr;
    logic [2:0]               size;
    logic [7:0]               len;
    logic [1:0]               burst;
    logic [`BUS_AXI_ID_W-1:0] id;
  } axi_ar_t;

  // aw carries the same fields as ar
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [`BUS_AXI_DATA_W-1:0] data;
    logic [`BUS_AXI_STRB_W-1:0] strb;
    logic                       last;
  } axi_w_t;

  typedef struct packed {
    logic [`BUS_AXI_DATA_W-1:0] data;
    logic [`BUS_AXI_ID_W-1:0]   id;
    logic [1:0]                 resp;
    logic                       last;
  } axi_r_t;

  // aligned load data back to the arbiter
  typedef struct packed {
    logic [`BUS_DATA_W-1:0] data;
    req_owner_e             owner;
  } bus_rd_rsp_t;

endpackage

//--- source/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// requester side widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// axi master port widths
`define BUS_AXI_DATA_W 64
`define BUS_AXI_STRB_W 8
`define BUS_AXI_ID_W 4

// clint mtime, low and high word
`define BUS_MTIME_LO 32'h0200_BFF8
`define BUS_MTIME_HI 32'h0200_BFFC

// arid values, they mark which requester owns a read
`define BUS_ID_IFU 4'd0
`define BUS_ID_LSU 4'd1

`endif
